//--- Bender.yml
package:
  name: video_frame_store

sources:
  - source/video_pkg.sv
  - source/video_timing.sv
  - source/pixel_scanout.sv
  - source/frame_store.sv
  - source/buffer_swap.sv
  - source/bus_arbiter.sv
  - source/fill_engine.sv
  - source/video_top.sv
  - target: simulation
    files:
      - bench/video_tb.sv

//--- bench/video_tb.sv
`timescale 1ns/1ps

module video_tb import video_pkg::*; ();

    // Small video mode with an 8x6 buffer shown at 2x on a 16x12 raster
    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_ACTIVE     = 12;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam bit SYNC_POL     = 1'b0;
    localparam int BUF_W        = 8;
    localparam int BUF_H        = 6;
    localparam int SCALE        = 2;
    localparam int ADDR_W       = $clog2(BUF_W * BUF_H);
    localparam int N_PIX        = BUF_W * BUF_H;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TESTS    = 5;
    localparam int TIMEOUT_NS   = NUM_TESTS * 10 * FRAME_CYCLES * CLK_PERIOD;
    localparam int SEED         = 32'h1b4e_6c97;

    logic               clk_display;
    logic               rstn_display;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [ADDR_W-1:0]  wb_adr;
    pixel_t             wb_dat_w;
    pixel_t             wb_dat_r;
    logic               wb_ack;
    logic               frame_commit;
    logic               fill_start;
    pixel_t             fill_color;
    logic               front_sel;
    logic               frame_swapped;
    logic               fill_busy;
    logic               fill_done;
    logic [COLOR_W-1:0] vga_red;
    logic [COLOR_W-1:0] vga_green;
    logic [COLOR_W-1:0] vga_blue;
    logic               vga_hsync;
    logic               vga_vsync;
    logic               video_de;

    // Reference image of both banks
    pixel_t model [2][N_PIX];
    logic   model_front;
    logic   expect_swap;
    int     error_count;
    int     since_de;
    int     fill_done_count;
    time    last_swap_time;
    time    last_ack_time;

    video_top #(
        .H_ACTIVE   (H_ACTIVE),
        .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_ACTIVE   (V_ACTIVE),
        .V_FRONT    (V_FRONT),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK),
        .SYNC_POL   (SYNC_POL),
        .BUF_WIDTH  (BUF_W),
        .BUF_HEIGHT (BUF_H),
        .SCALE      (SCALE)
    ) UUT (.*);

    initial clk_display = 1'b0;
    always #(CLK_PERIOD / 2) clk_display = ~clk_display;

    //////////////////////////////
    // Checker and bus tasks
    //////////////////////////////

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Drops the request after ack and checks that ack lasted one cycle
    task automatic end_transfer();
        @(posedge clk_display);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk_display);
        check_eq(wb_ack, 1'b0, "ack longer than one cycle");
    endtask

    task automatic wb_write(input int adr, input pixel_t dat);
        @(posedge clk_display);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= ADDR_W'(adr);
        wb_dat_w <= dat;
        @(negedge clk_display);
        while (!wb_ack) @(negedge clk_display);
        model[!model_front][adr] = dat;
        last_ack_time = $time;
        end_transfer();
    endtask

    task automatic wb_read(input int adr, output pixel_t dat);
        @(posedge clk_display);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= ADDR_W'(adr);
        @(negedge clk_display);
        while (!wb_ack) @(negedge clk_display);
        dat = wb_dat_r;
        end_transfer();
    endtask

    task automatic commit_frame();
        @(posedge clk_display);
        frame_commit <= 1'b1;
        expect_swap = 1'b1;
        @(posedge clk_display);
        frame_commit <= 1'b0;
    endtask

    task automatic wait_swap();
        @(negedge clk_display);
        while (!frame_swapped) @(negedge clk_display);
    endtask

    // One full frame after the vsync active edge compared with the front bank
    task automatic capture_frame();
        int     n;
        int     x;
        int     y;
        logic   prev_vs;
        pixel_t got;
        n = 0;
        @(negedge clk_display);
        prev_vs = vga_vsync;
        @(negedge clk_display);
        while (!(prev_vs != SYNC_POL && vga_vsync == SYNC_POL)) begin
            prev_vs = vga_vsync;
            @(negedge clk_display);
        end
        while (n < H_ACTIVE * V_ACTIVE) begin
            @(negedge clk_display);
            got = {vga_red, vga_green, vga_blue};
            if (video_de) begin
                x = n % H_ACTIVE;
                y = n / H_ACTIVE;
                check_eq(got, model[model_front][(y / SCALE) * BUF_W + x / SCALE],
                         $sformatf("screen pixel %0d,%0d", x, y));
                n = n + 1;
            end else begin
                check_eq(got, 0, "color while video_de low");
            end
        end
    endtask

    // Tracks swaps, fill_done pulses and the distance to the last visible pixel
    always @(negedge clk_display) begin
        if (video_de) begin
            since_de = 0;
        end else begin
            since_de = since_de + 1;
        end
        if (fill_done) begin
            fill_done_count = fill_done_count + 1;
        end
        if (frame_swapped) begin
            model_front = !model_front;
            last_swap_time = $time;
            check_eq(front_sel, model_front, "front_sel after swap");
            check_eq(expect_swap, 1'b1, "frame_swapped without commit");
            check_eq(since_de, H_TOTAL - H_ACTIVE, "swap not at blanking start");
            expect_swap = 1'b0;
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_values();
        @(negedge clk_display);
        check_eq(wb_ack, 1'b0, "wb_ack after reset");
        check_eq(frame_swapped, 1'b0, "frame_swapped after reset");
        check_eq(fill_done, 1'b0, "fill_done after reset");
        check_eq(fill_busy, 1'b0, "fill_busy after reset");
        check_eq(video_de, 1'b0, "video_de after reset");
        check_eq(front_sel, 1'b0, "front_sel after reset");
        check_eq(vga_hsync, !SYNC_POL, "hsync after reset");
        check_eq(vga_vsync, !SYNC_POL, "vsync after reset");
    endtask

    task automatic random_write_read();
        int     written[$];
        int     adr;
        pixel_t got;
        for (int i = 0; i < 20; i++) begin
            adr = $urandom_range(0, N_PIX - 1);
            wb_write(adr, pixel_t'($urandom_range(0, 4095)));
            written.push_back(adr);
        end
        foreach (written[i]) begin
            wb_read(written[i], got);
            check_eq(got, model[!model_front][written[i]], "read back");
        end
    endtask

    task automatic commit_and_swap();
        logic old_front;
        for (int i = 0; i < N_PIX; i++) begin
            wb_write(i, pixel_t'($urandom_range(0, 4095)));
        end
        old_front = model_front;
        commit_frame();
        wait_swap();
        check_eq(front_sel, !old_front, "front_sel did not toggle");
        capture_frame();
    endtask

    task automatic held_write();
        int     adr;
        pixel_t dat;
        pixel_t got;
        adr = $urandom_range(0, N_PIX - 1);
        dat = pixel_t'($urandom_range(0, 4095));
        commit_frame();
        wb_write(adr, dat);
        check_eq(last_ack_time > last_swap_time, 1'b1, "held write acked before swap");
        check_eq(expect_swap, 1'b0, "no swap before held write");
        wb_read(adr, got);
        check_eq(got, dat, "held write in new back bank");
    endtask

    task automatic fill_during_reads();
        pixel_t color;
        pixel_t got;
        pixel_t old;
        int     adr;
        color = pixel_t'($urandom_range(0, 4095));
        fill_done_count = 0;
        fork
            begin
                @(posedge clk_display);
                fill_start <= 1'b1;
                fill_color <= color;
                @(posedge clk_display);
                fill_start <= 1'b0;
                @(negedge clk_display);
                while (!fill_done) @(negedge clk_display);
            end
            begin
                for (int i = 0; i < 12; i++) begin
                    adr = $urandom_range(0, N_PIX - 1);
                    old = model[!model_front][adr];
                    wb_read(adr, got);
                    check_eq((got === old) || (got === color), 1'b1, "read during fill");
                end
            end
        join
        repeat (4) @(negedge clk_display);
        check_eq(fill_done_count, 1, "fill_done pulses");
        check_eq(fill_busy, 1'b0, "fill_busy after fill");
        for (int i = 0; i < N_PIX; i++) begin
            model[!model_front][i] = color;
        end
        for (int i = 0; i < N_PIX; i++) begin
            wb_read(i, got);
            check_eq(got, color, $sformatf("fill read back at %0d", i));
        end
        commit_frame();
        wait_swap();
        capture_frame();
    endtask

    initial begin
        void'($urandom(SEED));
        error_count     = 0;
        since_de        = 0;
        fill_done_count = 0;
        model_front     = 1'b0;
        expect_swap     = 1'b0;
        last_swap_time  = 0;
        last_ack_time   = 0;
        rstn_display    = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        frame_commit    = 1'b0;
        fill_start      = 1'b0;
        fill_color      = '0;
        repeat (8) @(posedge clk_display);
        rstn_display <= 1'b1;

        reset_values();
        random_write_read();
        commit_and_swap();
        held_write();
        fill_during_reads();

        $display("Tests done with %0d errors", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog allows ten frames per test
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, a handshake never completed", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- files.f
source/video_pkg.sv
source/video_timing.sv
source/pixel_scanout.sv
source/frame_store.sv
source/buffer_swap.sv
source/bus_arbiter.sv
source/fill_engine.sv
source/video_top.sv
bench/video_tb.sv

//--- source/buffer_swap.sv
`timescale 1ns/1ps

module buffer_swap (
    input  logic clk_display,
    input  logic rstn_display,
    input  logic frame_commit,
    input  logic vblank_start,
    output logic front_sel,
    output logic write_hold,
    output logic frame_swapped
);
    logic pending;
    logic swap;

    assign swap       = vblank_start && pending;
    assign write_hold = pending;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            pending       <= 1'b0;
            front_sel     <= 1'b0;
            frame_swapped <= 1'b0;
        end else begin
            // A commit in the swap cycle is kept for the following frame
            pending       <= frame_commit || (pending && !vblank_start);
            frame_swapped <= swap;
            if (swap) begin
                front_sel <= !front_sel;
            end
        end
    end

    // Host sees every bank change
    assert property (@(posedge clk_display) disable iff (!rstn_display)
        $changed(front_sel) |-> frame_swapped);

endmodule

//--- source/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import video_pkg::*; #(
    parameter int ADDR_W = $clog2(DEF_BUF_WIDTH * DEF_BUF_HEIGHT)
) (
    input  logic              clk_display,
    input  logic              rstn_display,
    input  logic              write_hold,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  pixel_t            wb_dat_w,
    output pixel_t            wb_dat_r,
    output logic              wb_ack,
    input  logic              fill_cyc,
    input  logic              fill_stb,
    input  logic [ADDR_W-1:0] fill_adr,
    input  pixel_t            fill_dat_w,
    output logic              fill_ack,
    input  pixel_t            mem_dat_r,
    input  logic              mem_ack,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_adr,
    output pixel_t            mem_dat_w
);
    logic gnt_host;
    logic gnt_fill;
    logic last_fill;
    logic nxt_host;
    logic nxt_fill;
    logic host_req;
    logic fill_req;

    assign host_req = wb_cyc && wb_stb;
    assign fill_req = fill_cyc && fill_stb;

    //////////////////////////////
    // Grant
    //////////////////////////////

    always_comb begin
        nxt_host = gnt_host && wb_cyc;
        nxt_fill = gnt_fill && fill_cyc;
        if (!nxt_host && !nxt_fill) begin
            // On a tie the master served last steps aside
            if (host_req && (!fill_req || last_fill)) begin
                nxt_host = 1'b1;
            end else if (fill_req) begin
                nxt_fill = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            gnt_host  <= 1'b0;
            gnt_fill  <= 1'b0;
            last_fill <= 1'b0;
        end else begin
            gnt_host <= nxt_host;
            gnt_fill <= nxt_fill;
            if (nxt_host || nxt_fill) begin
                last_fill <= nxt_fill;
            end
        end
    end

    //////////////////////////////
    // Request mux
    //////////////////////////////

    // Held writes wait here, reads go through
    assign mem_stb   = gnt_host ? (wb_stb && !(wb_we && write_hold))
                                : (gnt_fill && fill_stb && !write_hold);
    assign mem_we    = gnt_fill || wb_we;
    assign mem_adr   = gnt_fill ? fill_adr : wb_adr;
    assign mem_dat_w = gnt_fill ? fill_dat_w : wb_dat_w;

    assign wb_dat_r  = mem_dat_r;
    assign wb_ack    = gnt_host && mem_ack;
    assign fill_ack  = gnt_fill && mem_ack;

    assert property (@(posedge clk_display) disable iff (!rstn_display)
        !(gnt_host && gnt_fill));

endmodule

//--- source/fill_engine.sv
`timescale 1ns/1ps

module fill_engine import video_pkg::*; #(
    parameter int BUF_WIDTH  = DEF_BUF_WIDTH,
    parameter int BUF_HEIGHT = DEF_BUF_HEIGHT,
    parameter int ADDR_W     = $clog2(DEF_BUF_WIDTH * DEF_BUF_HEIGHT)
) (
    input  logic              clk_display,
    input  logic              rstn_display,
    input  logic              fill_start,
    input  pixel_t            fill_color,
    input  logic              fill_ack,
    output logic              fill_cyc,
    output logic              fill_stb,
    output logic [ADDR_W-1:0] fill_adr,
    output pixel_t            fill_dat_w,
    output logic              fill_busy,
    output logic              fill_done
);
    localparam int LAST_ADR = BUF_WIDTH * BUF_HEIGHT - 1;

    logic req;

    assign fill_cyc = req;
    assign fill_stb = req;

    // Color stays fixed for the whole pass
    always_ff @(posedge clk_display) begin
        if (fill_start && !fill_busy) begin
            fill_dat_w <= fill_color;
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            req       <= 1'b0;
            fill_adr  <= '0;
        end else begin
            fill_done <= 1'b0;
            if (!fill_busy) begin
                if (fill_start) begin
                    fill_busy <= 1'b1;
                    req       <= 1'b1;
                    fill_adr  <= '0;
                end
            end else if (req) begin
                if (fill_ack) begin
                    req <= 1'b0;
                    if (fill_adr == ADDR_W'(LAST_ADR)) begin
                        fill_busy <= 1'b0;
                        fill_done <= 1'b1;
                    end else begin
                        fill_adr <= fill_adr + 1'b1;
                    end
                end
            end else begin
                // cyc drops for a cycle so the host can win the bus
                req <= 1'b1;
            end
        end
    end

endmodule

//--- source/frame_store.sv
`timescale 1ns/1ps

module frame_store import video_pkg::*; #(
    parameter int ADDR_W = $clog2(DEF_BUF_WIDTH * DEF_BUF_HEIGHT)
) (
    input  logic              clk_display,
    input  logic              mem_stb,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_adr,
    input  pixel_t            mem_dat_w,
    input  logic              front_sel,
    input  logic [ADDR_W-1:0] scan_adr,
    output pixel_t            mem_dat_r,
    output logic              mem_ack,
    output pixel_t            scan_dat
);
    localparam int DEPTH = 2 ** ADDR_W;

    pixel_t bank [2][DEPTH];
    logic   back_sel;

    // Bus side always sees the bank that is not on screen
    assign back_sel = !front_sel;

    always_ff @(posedge clk_display) begin
        if (mem_stb && mem_we && !mem_ack) begin
            bank[back_sel][mem_adr] <= mem_dat_w;
        end
        mem_dat_r <= bank[back_sel][mem_adr];
        scan_dat  <= bank[front_sel][scan_adr];
        // Single wait state so ack drops while stb is still held
        mem_ack   <= mem_stb && !mem_ack;
    end

    assert property (@(posedge clk_display)
        mem_ack |-> $past(mem_stb));

endmodule

//--- source/pixel_scanout.sv
`timescale 1ns/1ps

module pixel_scanout import video_pkg::*; #(
    parameter bit SYNC_POL   = DEF_SYNC_POL,
    parameter int BUF_WIDTH  = DEF_BUF_WIDTH,
    parameter int BUF_HEIGHT = DEF_BUF_HEIGHT,
    parameter int SCALE      = DEF_SCALE,
    parameter int ADDR_W     = $clog2(DEF_BUF_WIDTH * DEF_BUF_HEIGHT)
) (
    input  logic               clk_display,
    input  logic               rstn_display,
    input  logic [CNT_W-1:0]   h_count,
    input  logic [CNT_W-1:0]   v_count,
    input  logic               active,
    input  logic               hsync_raw,
    input  logic               vsync_raw,
    input  pixel_t             scan_dat,
    output logic [ADDR_W-1:0]  scan_adr,
    output logic [COLOR_W-1:0] vga_red,
    output logic [COLOR_W-1:0] vga_green,
    output logic [COLOR_W-1:0] vga_blue,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic               video_de
);
    localparam int DISP_W = BUF_WIDTH * SCALE;
    localparam int DISP_H = BUF_HEIGHT * SCALE;
    localparam int SUB_W  = $clog2(SCALE + 1);
    localparam int X_W    = $clog2(BUF_WIDTH + 1);

    logic [SUB_W-1:0]  sub_x;
    logic [SUB_W-1:0]  sub_y;
    logic [X_W-1:0]    buf_x;
    logic [ADDR_W-1:0] row_base;
    logic              de_d1;
    logic              hsync_d1;
    logic              vsync_d1;

    // Buffer coordinate steps once every SCALE screen pixels
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            sub_x    <= '0;
            buf_x    <= '0;
            sub_y    <= '0;
            row_base <= '0;
        end else begin
            if (h_count >= DISP_W) begin
                sub_x <= '0;
                buf_x <= '0;
            end else if (sub_x == SUB_W'(SCALE - 1)) begin
                sub_x <= '0;
                buf_x <= buf_x + 1'b1;
            end else begin
                sub_x <= sub_x + 1'b1;
            end

            // Row base moves at the last visible pixel of each line
            if (v_count >= DISP_H) begin
                sub_y    <= '0;
                row_base <= '0;
            end else if (h_count == CNT_W'(DISP_W - 1)) begin
                if (sub_y == SUB_W'(SCALE - 1)) begin
                    sub_y    <= '0;
                    row_base <= row_base + ADDR_W'(BUF_WIDTH);
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end
        end
    end

    assign scan_adr = row_base + ADDR_W'(buf_x);

    // Stage 1 covers the RAM read, stage 2 drives the pins
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            de_d1     <= 1'b0;
            hsync_d1  <= !SYNC_POL;
            vsync_d1  <= !SYNC_POL;
            video_de  <= 1'b0;
            vga_hsync <= !SYNC_POL;
            vga_vsync <= !SYNC_POL;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            de_d1     <= active;
            hsync_d1  <= hsync_raw;
            vsync_d1  <= vsync_raw;
            video_de  <= de_d1;
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_red   <= de_d1 ? scan_dat.red   : '0;
            vga_green <= de_d1 ? scan_dat.green : '0;
            vga_blue  <= de_d1 ? scan_dat.blue  : '0;
        end
    end

endmodule

//--- source/video_pkg.sv
package video_pkg;

    // Color depth of one channel on the VGA pins
    localparam int COLOR_W = 4;

    // Raster counters cover totals up to 4095
    localparam int CNT_W = 12;

    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } pixel_t;

    // 640x480 at 60 Hz
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;
    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;
    localparam bit DEF_SYNC_POL = 1'b0;

    // Stored image shown at 4x
    localparam int DEF_BUF_WIDTH  = 160;
    localparam int DEF_BUF_HEIGHT = 120;
    localparam int DEF_SCALE      = 4;

endpackage

//--- source/video_timing.sv
`timescale 1ns/1ps

module video_timing import video_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FRONT  = DEF_H_FRONT,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BACK   = DEF_H_BACK,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FRONT  = DEF_V_FRONT,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BACK   = DEF_V_BACK,
    parameter bit SYNC_POL = DEF_SYNC_POL
) (
    input  logic             clk_display,
    input  logic             rstn_display,
    output logic [CNT_W-1:0] h_count,
    output logic [CNT_W-1:0] v_count,
    output logic             active,
    output logic             hsync_raw,
    output logic             vsync_raw,
    output logic             vblank_start
);
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic h_in_sync;
    logic v_in_sync;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == CNT_W'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == CNT_W'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign active    = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
    assign h_in_sync = (h_count >= H_SYNC_START) && (h_count < H_SYNC_START + H_SYNC);
    assign v_in_sync = (v_count >= V_SYNC_START) && (v_count < V_SYNC_START + V_SYNC);

    // Sync leaves here already at line polarity
    assign hsync_raw = h_in_sync ? SYNC_POL : !SYNC_POL;
    assign vsync_raw = v_in_sync ? SYNC_POL : !SYNC_POL;

    // First cycle of the first blanking line
    assign vblank_start = (h_count == '0) && (v_count == CNT_W'(V_ACTIVE));

    assert property (@(posedge clk_display) disable iff (!rstn_display)
        h_count < H_TOTAL);

endmodule

//--- source/video_top.sv
`timescale 1ns/1ps

module video_top import video_pkg::*; #(
    parameter int H_ACTIVE   = DEF_H_ACTIVE,
    parameter int H_FRONT    = DEF_H_FRONT,
    parameter int H_SYNC     = DEF_H_SYNC,
    parameter int H_BACK     = DEF_H_BACK,
    parameter int V_ACTIVE   = DEF_V_ACTIVE,
    parameter int V_FRONT    = DEF_V_FRONT,
    parameter int V_SYNC     = DEF_V_SYNC,
    parameter int V_BACK     = DEF_V_BACK,
    parameter bit SYNC_POL   = DEF_SYNC_POL,
    parameter int BUF_WIDTH  = DEF_BUF_WIDTH,
    parameter int BUF_HEIGHT = DEF_BUF_HEIGHT,
    parameter int SCALE      = DEF_SCALE,
    localparam int ADDR_W    = $clog2(BUF_WIDTH * BUF_HEIGHT)
) (
    input  logic               clk_display,
    input  logic               rstn_display,
    // Host Wishbone slave
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [ADDR_W-1:0]  wb_adr,
    input  pixel_t             wb_dat_w,
    output pixel_t             wb_dat_r,
    output logic               wb_ack,
    // Frame control
    input  logic               frame_commit,
    input  logic               fill_start,
    input  pixel_t             fill_color,
    output logic               front_sel,
    output logic               frame_swapped,
    output logic               fill_busy,
    output logic               fill_done,
    // VGA
    output logic [COLOR_W-1:0] vga_red,
    output logic [COLOR_W-1:0] vga_green,
    output logic [COLOR_W-1:0] vga_blue,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic               video_de
);
    logic [CNT_W-1:0]  h_count;
    logic [CNT_W-1:0]  v_count;
    logic              active;
    logic              hsync_raw;
    logic              vsync_raw;
    logic              vblank_start;
    logic [ADDR_W-1:0] scan_adr;
    pixel_t            scan_dat;
    logic              write_hold;

    logic              fill_cyc;
    logic              fill_stb;
    logic              fill_ack;
    logic [ADDR_W-1:0] fill_adr;
    pixel_t            fill_dat_w;

    logic              mem_stb;
    logic              mem_we;
    logic              mem_ack;
    logic [ADDR_W-1:0] mem_adr;
    pixel_t            mem_dat_w;
    pixel_t            mem_dat_r;

    //////////////////////////////
    // Raster and scanout
    //////////////////////////////

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .SYNC_POL (SYNC_POL)
    ) u_timing (.*);

    pixel_scanout #(
        .SYNC_POL   (SYNC_POL),
        .BUF_WIDTH  (BUF_WIDTH),
        .BUF_HEIGHT (BUF_HEIGHT),
        .SCALE      (SCALE),
        .ADDR_W     (ADDR_W)
    ) u_scanout (.*);

    //////////////////////////////
    // Double buffer
    //////////////////////////////

    buffer_swap u_swap (.*);

    frame_store #(
        .ADDR_W (ADDR_W)
    ) u_store (.*);

    //////////////////////////////
    // Write port masters
    //////////////////////////////

    bus_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_arbiter (.*);

    fill_engine #(
        .BUF_WIDTH  (BUF_WIDTH),
        .BUF_HEIGHT (BUF_HEIGHT),
        .ADDR_W     (ADDR_W)
    ) u_fill (.*);

endmodule
